/* logic/instrDecPkg.sv */
package instrDecPkg;

    // ----------------------------------------
    // Widths
    // ----------------------------------------
    localparam int opcodeWidth = 7;         // Opcode field
    localparam int aluOpWidth  = 6;         // ALU operation code
    localparam int opcodeCount = 97;        // Opcode slots 0..96, NOP included

    // ----------------------------------------
    // Opcodes, numbering of the original ISA
    // ----------------------------------------
    localparam logic [opcodeWidth-1:0]
        opLod   = 7'd0,                     // Load acc from memory
        opPLod  = 7'd1,                     // Push, then load
        opLdi   = 7'd2,                     // Indirect load
        opIli   = 7'd3,                     // Indirect load, bit-reversed address
        opSet   = 7'd4,                     // Store acc to memory
        opSetP  = 7'd5,                     // Store, then pop
        opSti   = 7'd6,                     // Indirect store
        opIsi   = 7'd7,                     // Indirect store, bit-reversed address
        opPsh   = 7'd8,
        opPop   = 7'd9,
        opInn   = 7'd10,                    // Input port read
        opPInn  = 7'd12,                    // Push, then input
        opOut   = 7'd14,                    // Output port write
        opAdd   = 7'd19,
        opSAdd  = 7'd20,                    // Stack operand form
        opMlt   = 7'd23,
        opSMlt  = 7'd24,
        opDiv   = 7'd27,
        opSDiv  = 7'd28,
        opMod   = 7'd31,
        opSMod  = 7'd32,
        opSgn   = 7'd33,                    // Copy sign of one operand onto the other
        opSSgn  = 7'd34,
        opNeg   = 7'd37,                    // Two's complement of acc
        opNegM  = 7'd38,                    // Same on memory operand
        opPNegM = 7'd39,                    // Push, then memory form
        opAbs   = 7'd43,
        opAbsM  = 7'd44,
        opPAbsM = 7'd45,
        opPst   = 7'd49,                    // Clamp negative to zero
        opPstM  = 7'd50,
        opPPstM = 7'd51,
        opNrm   = 7'd55,                    // Divide by constant
        opNrmM  = 7'd56,
        opPNrmM = 7'd57,
        opAnd   = 7'd64,
        opSAnd  = 7'd65,
        opOrr   = 7'd66,
        opSOrr  = 7'd67,
        opXor   = 7'd68,
        opSXor  = 7'd69,
        opInv   = 7'd70,                    // Bitwise invert
        opInvM  = 7'd71,
        opPInvM = 7'd72,
        opLan   = 7'd73,                    // Logical and
        opSLan  = 7'd74,
        opLor   = 7'd75,                    // Logical or
        opSLor  = 7'd76,
        opLin   = 7'd77,                    // Logical not
        opLinM  = 7'd78,
        opPLinM = 7'd79,
        opLes   = 7'd80,
        opSLes  = 7'd81,
        opGre   = 7'd84,
        opSGre  = 7'd85,
        opEqu   = 7'd88,
        opSEqu  = 7'd89,
        opShl   = 7'd90,
        opSShl  = 7'd91,
        opShr   = 7'd92,
        opSShr  = 7'd93,
        opSrs   = 7'd94,                    // Arithmetic shift right
        opSSrs  = 7'd95,
        opNop   = 7'd96;                    // Holds the ALU code

    // ----------------------------------------
    // ALU operation codes
    // ----------------------------------------
    localparam logic [aluOpWidth-1:0]
        aluPass = 6'd0,                     // No ALU work
        aluLoad = 6'd1,
        aluAdd  = 6'd2,
        aluMlt  = 6'd4,
        aluDiv  = 6'd6,
        aluMod  = 6'd8,
        aluSgn  = 6'd9,
        aluNeg  = 6'd11,
        aluNegM = 6'd12,
        aluAbs  = 6'd15,
        aluAbsM = 6'd16,
        aluPst  = 6'd19,
        aluPstM = 6'd20,
        aluNrm  = 6'd23,
        aluNrmM = 6'd24,
        aluAnd  = 6'd29,
        aluOrr  = 6'd30,
        aluXor  = 6'd31,
        aluInv  = 6'd32,
        aluInvM = 6'd33,
        aluLan  = 6'd34,
        aluLor  = 6'd35,
        aluLin  = 6'd36,
        aluLinM = 6'd37,
        aluLes  = 6'd38,
        aluGre  = 6'd40,
        aluEqu  = 6'd42,
        aluShl  = 6'd43,
        aluShr  = 6'd44,
        aluSrs  = 6'd45;

    // ----------------------------------------
    // Implemented-instruction mask
    // ----------------------------------------
    // Everything is on except float opcodes and the flow-control slots 15..18
    function automatic logic [opcodeCount-1:0] buildEnable();
        logic [opcodeCount-1:0] mask;
        mask = '1;
        mask[11] = 1'b0;                    // F_INN
        mask[13] = 1'b0;                    // PF_INN
        for (int i = 15; i <= 18; i++) begin
            mask[i] = 1'b0;                 // Handled by prefetch, not here
        end
        mask[22:21] = 2'b00;                // Float add
        mask[26:25] = 2'b00;                // Float mult
        mask[30:29] = 2'b00;                // Float div
        mask[36:35] = 2'b00;                // Float sign
        mask[42:40] = 3'b000;               // Float neg
        mask[48:46] = 3'b000;               // Float abs
        mask[54:52] = 3'b000;               // Float pst
        mask[63:58] = 6'b000000;            // I2F and F2I forms
        mask[83:82] = 2'b00;                // Float less-than
        mask[87:86] = 2'b00;                // Float greater-than
        return mask;
    endfunction

    localparam logic [opcodeCount-1:0] instrEnable = buildEnable();

endpackage

/* logic/opcodeMatch.sv */
`timescale 1ns/10ps

module opcodeMatch import instrDecPkg::*; (
    input  logic [opcodeWidth-1:0] opcode,      // Raw opcode from fetch
    output logic [opcodeCount-1:0] matchVec     // One-hot, bit index = opcode value
);

    // ----------------------------------------
    // Gated one-hot decode
    // ----------------------------------------
    // Values 97..127 have no slot, so they leave the vector all zero
    for (genvar i = 0; i < opcodeCount; i++) begin : gMatch
        if (instrEnable[i]) begin : gOn
            assign matchVec[i] = (opcode == opcodeWidth'(i));  // Implemented slot
        end else begin : gOff
            assign matchVec[i] = 1'b0;                          // Dropped or reserved
        end
    end

endmodule

/* logic/ctrlStrobes.sv */
`timescale 1ns/10ps

module ctrlStrobes import instrDecPkg::*; (
    input  logic [opcodeCount-1:0] matchVec,    // One-hot opcode match
    output logic                   push,        // Data stack push
    output logic                   pop,         // Data stack pop
    output logic                   memWr,       // Data memory write
    output logic                   reqIn,       // Input port request
    output logic                   outEn,       // Output port enable
    output logic                   ldi,         // Indirect load
    output logic                   sti,         // Indirect store
    output logic                   fft          // Bit-reversed indirect address
);

    // ----------------------------------------
    // Stack control
    // ----------------------------------------
    assign push = matchVec[opPLod]  | matchVec[opPsh]   | matchVec[opPInn]  |
                  matchVec[opPNegM] | matchVec[opPAbsM] | matchVec[opPPstM] |
                  matchVec[opPNrmM] | matchVec[opPInvM] | matchVec[opPLinM];  // P_ forms

    // Stores that consume the stack top, POP itself, and all S_ operand forms
    assign pop  = matchVec[opSetP]  | matchVec[opSti]   | matchVec[opIsi]   |
                  matchVec[opPop]   |
                  matchVec[opSAdd]  | matchVec[opSMlt]  | matchVec[opSDiv]  |
                  matchVec[opSMod]  | matchVec[opSSgn]  |
                  matchVec[opSAnd]  | matchVec[opSOrr]  | matchVec[opSXor]  |
                  matchVec[opSLan]  | matchVec[opSLor]  |
                  matchVec[opSLes]  | matchVec[opSGre]  | matchVec[opSEqu]  |
                  matchVec[opSShl]  | matchVec[opSShr]  | matchVec[opSSrs];

    // ----------------------------------------
    // Memory and I/O
    // ----------------------------------------
    assign memWr = matchVec[opSet] | matchVec[opSetP] |
                   matchVec[opSti] | matchVec[opIsi];       // Direct and indirect stores

    assign reqIn = matchVec[opInn] | matchVec[opPInn];      // Integer input only
    assign outEn = matchVec[opOut];

    // ----------------------------------------
    // Indirect addressing
    // ----------------------------------------
    assign ldi = matchVec[opLdi] | matchVec[opIli];         // Address from acc on load
    assign sti = matchVec[opSti] | matchVec[opIsi];         // Address from acc on store
    assign fft = matchVec[opIli] | matchVec[opIsi];         // Reverse address bits, FFT order

endmodule

/* logic/aluOpEncoder.sv */
`timescale 1ns/10ps

module aluOpEncoder import instrDecPkg::*; (
    input  logic                   clk,
    input  logic                   rstN,        // Sync, active low
    input  logic [opcodeCount-1:0] matchVec,    // One-hot opcode match
    output logic [aluOpWidth-1:0]  aluOp        // Registered ALU code
);

    logic [aluOpWidth-1:0] aluNext;             // Code for the current opcode

    // ----------------------------------------
    // Match vector to ALU code
    // ----------------------------------------
    // matchVec is one-hot or zero, so item order does not matter
    always_comb begin
        case (1'b1)
            matchVec[opLod], matchVec[opPLod],
            matchVec[opLdi], matchVec[opIli],
            matchVec[opSetP], matchVec[opPop]:    aluNext = aluLoad;  // Acc takes operand
            matchVec[opAdd], matchVec[opSAdd]:    aluNext = aluAdd;
            matchVec[opMlt], matchVec[opSMlt]:    aluNext = aluMlt;
            matchVec[opDiv], matchVec[opSDiv]:    aluNext = aluDiv;
            matchVec[opMod], matchVec[opSMod]:    aluNext = aluMod;
            matchVec[opSgn], matchVec[opSSgn]:    aluNext = aluSgn;
            matchVec[opNeg]:                      aluNext = aluNeg;
            matchVec[opNegM], matchVec[opPNegM]:  aluNext = aluNegM;  // Memory operand
            matchVec[opAbs]:                      aluNext = aluAbs;
            matchVec[opAbsM], matchVec[opPAbsM]:  aluNext = aluAbsM;
            matchVec[opPst]:                      aluNext = aluPst;
            matchVec[opPstM], matchVec[opPPstM]:  aluNext = aluPstM;
            matchVec[opNrm]:                      aluNext = aluNrm;
            matchVec[opNrmM], matchVec[opPNrmM]:  aluNext = aluNrmM;
            matchVec[opAnd], matchVec[opSAnd]:    aluNext = aluAnd;
            matchVec[opOrr], matchVec[opSOrr]:    aluNext = aluOrr;
            matchVec[opXor], matchVec[opSXor]:    aluNext = aluXor;
            matchVec[opInv]:                      aluNext = aluInv;
            matchVec[opInvM], matchVec[opPInvM]:  aluNext = aluInvM;
            matchVec[opLan], matchVec[opSLan]:    aluNext = aluLan;
            matchVec[opLor], matchVec[opSLor]:    aluNext = aluLor;
            matchVec[opLin]:                      aluNext = aluLin;
            matchVec[opLinM], matchVec[opPLinM]:  aluNext = aluLinM;
            matchVec[opLes], matchVec[opSLes]:    aluNext = aluLes;
            matchVec[opGre], matchVec[opSGre]:    aluNext = aluGre;
            matchVec[opEqu], matchVec[opSEqu]:    aluNext = aluEqu;
            matchVec[opShl], matchVec[opSShl]:    aluNext = aluShl;
            matchVec[opShr], matchVec[opSShr]:    aluNext = aluShr;
            matchVec[opSrs], matchVec[opSSrs]:    aluNext = aluSrs;
            default:                              aluNext = aluPass;  // Stores, I/O, none
        endcase
    end

    // ----------------------------------------
    // Output register with NOP hold
    // ----------------------------------------
    always_ff @(posedge clk) begin
        if (!rstN) begin
            aluOp <= aluPass;                   // Idle code out of reset
        end else if (!matchVec[opNop]) begin
            aluOp <= aluNext;                   // NOP keeps the previous code
        end
    end

endmodule

/* logic/instrDec.sv */
`timescale 1ns/10ps

module instrDec import instrDecPkg::*; (
    input  logic                   clk,
    input  logic                   rstN,        // Sync, active low
    input  logic [opcodeWidth-1:0] opcode,      // New opcode every cycle
    output logic                   push,        // Combinational strobes
    output logic                   pop,
    output logic                   memWr,
    output logic                   reqIn,
    output logic                   outEn,
    output logic                   ldi,
    output logic                   sti,
    output logic                   fft,
    output logic [aluOpWidth-1:0]  aluOp        // One cycle after opcode
);

    logic [opcodeCount-1:0] matchVec;           // Shared one-hot decode

    // ----------------------------------------
    // Decode stages
    // ----------------------------------------
    opcodeMatch uMatch (
        .opcode   (opcode),
        .matchVec (matchVec)
    );

    ctrlStrobes uStrobes (
        .matchVec (matchVec),
        .push     (push),
        .pop      (pop),
        .memWr    (memWr),
        .reqIn    (reqIn),
        .outEn    (outEn),
        .ldi      (ldi),
        .sti      (sti),
        .fft      (fft)
    );

    aluOpEncoder uAluOp (
        .clk      (clk),
        .rstN     (rstN),
        .matchVec (matchVec),
        .aluOp    (aluOp)
    );

endmodule

/* testbench/instrDec_props.sv */
`timescale 1ns/10ps

module instrDecProps import instrDecPkg::*; (
    input logic                   clk,
    input logic                   rstN,
    input logic [opcodeWidth-1:0] opcode,
    input logic                   push,
    input logic                   pop,
    input logic                   ldi,
    input logic                   sti,
    input logic                   fft,
    input logic [aluOpWidth-1:0]  aluOp
);

    int failCount = 0;                          // Assertion failures so far

    // ----------------------------------------
    // Strobe exclusivity
    // ----------------------------------------
    assert property (@(posedge clk) disable iff (!rstN) !(push && pop))
        else begin
            failCount++;
            $error("push and pop high together");       // Stack moves one way
        end
    assert property (@(posedge clk) disable iff (!rstN) !(ldi && sti))
        else begin
            failCount++;
            $error("ldi and sti high together");
        end
    assert property (@(posedge clk) disable iff (!rstN) fft |-> (ldi || sti))
        else begin
            failCount++;
            $error("fft without an indirect access");   // Only indirect forms reverse
        end

    // ----------------------------------------
    // NOP hold
    // ----------------------------------------
    assert property (@(posedge clk) disable iff (!rstN) (opcode == opNop) |=> $stable(aluOp))
        else begin
            failCount++;
            $error("aluOp changed after a NOP");
        end

endmodule

bind instrDec instrDecProps uProps (
    .clk(clk), .rstN(rstN), .opcode(opcode), .push(push), .pop(pop),
    .ldi(ldi), .sti(sti), .fft(fft), .aluOp(aluOp)
);

/* testbench/instrDecTb.sv */
`timescale 1ns/10ps

module instrDecTb;

    logic       clk;
    logic       rstN;
    logic [6:0] opcode;
    logic       push, pop, memWr, reqIn, outEn, ldi, sti, fft;
    logic [5:0] aluOp;

    logic [6:0] curOp;                          // Opcode now on the DUT input
    logic [5:0] aluModel;                       // Expected registered ALU code
    int         checkCount;
    int         errorCount;
    int         testChecks;                     // Counts at start of current test
    int         testErrors;
    int unsigned seed = 32'h16b3_c540;
    bit         released;

    instrDec uut (
        .clk(clk), .rstN(rstN), .opcode(opcode),
        .push(push), .pop(pop), .memWr(memWr), .reqIn(reqIn), .outEn(outEn),
        .ldi(ldi), .sti(sti), .fft(fft), .aluOp(aluOp)
    );

    always #2 clk = ~clk;                       // 4 ns period

    initial begin
        rstN = 1'b0;
        repeat (8) @(posedge clk);              // 8 cycles in reset
        rstN <= 1'b1;
    end

    // ----------------------------------------
    // Reference model
    // ----------------------------------------
    // Bits are {push, pop, memWr, reqIn, outEn, ldi, sti, fft}
    function automatic logic [7:0] expStrobes(input logic [6:0] op);
        logic [7:0] s;
        s = 8'h00;
        case (op)
            1, 8, 12, 39, 45, 51, 57, 72, 79: s[7] = 1'b1;         // P_ forms and PSH
            default: ;
        endcase
        case (op)
            5, 6, 7, 9, 20, 24, 28, 32, 34, 65, 67, 69,
            74, 76, 81, 85, 89, 91, 93, 95: s[6] = 1'b1;           // Stores with pop, S_ forms
            default: ;
        endcase
        s[5] = (op >= 4 && op <= 7);            // SET, SET_P, STI, ISI
        s[4] = (op == 10 || op == 12);
        s[3] = (op == 14);
        s[2] = (op == 2 || op == 3);
        s[1] = (op == 6 || op == 7);
        s[0] = (op == 3 || op == 7);            // Bit-reversed forms
        return s;
    endfunction

    function automatic logic [5:0] expAlu(input logic [6:0] op);
        case (op)
            0, 1, 2, 3, 5, 9: return 6'd1;      // Load type
            19, 20: return 6'd2;
            23, 24: return 6'd4;
            27, 28: return 6'd6;
            31, 32: return 6'd8;
            33, 34: return 6'd9;
            37:     return 6'd11;
            38, 39: return 6'd12;
            43:     return 6'd15;
            44, 45: return 6'd16;
            49:     return 6'd19;
            50, 51: return 6'd20;
            55:     return 6'd23;
            56, 57: return 6'd24;
            64, 65: return 6'd29;
            66, 67: return 6'd30;
            68, 69: return 6'd31;
            70:     return 6'd32;
            71, 72: return 6'd33;
            73, 74: return 6'd34;
            75, 76: return 6'd35;
            77:     return 6'd36;
            78, 79: return 6'd37;
            80, 81: return 6'd38;
            84, 85: return 6'd40;
            88, 89: return 6'd42;
            90, 91: return 6'd43;
            92, 93: return 6'd44;
            94, 95: return 6'd45;
            default: return 6'd0;               // Stores, I/O, dropped, undefined
        endcase
    endfunction

    function automatic bit isDropped(input logic [6:0] op);
        case (op)
            11, 13, 15, 16, 17, 18, 21, 22, 25, 26, 29, 30, 35, 36,
            40, 41, 42, 46, 47, 48, 52, 53, 54, 58, 59, 60, 61, 62, 63,
            82, 83, 86, 87: return 1'b1;        // Float and reserved slots
            default: return (op >= 97);
        endcase
    endfunction

    // ----------------------------------------
    // Check and drive helpers
    // ----------------------------------------
    task automatic checkEq(input string what, input logic [31:0] got, input logic [31:0] exp);
        checkCount++;
        assert (got === exp) else begin
            errorCount++;
            $display("CHECK FAILED at %0t ns: %s got 0x%0h expected 0x%0h",
                     $time, what, got, exp);
        end
    endtask

    // One clock: model update at the edge, new opcode, checks at the falling edge
    task automatic step(input logic [6:0] nextOp);
        @(posedge clk);
        if (!rstN) aluModel = 6'd0;
        else if (curOp != 7'd96) aluModel = expAlu(curOp);  // NOP holds
        opcode <= nextOp;
        curOp = nextOp;
        @(negedge clk);
        checkEq($sformatf("strobes for opcode %0d", curOp),
                {push, pop, memWr, reqIn, outEn, ldi, sti, fft}, expStrobes(curOp));
        checkEq($sformatf("aluOp with opcode %0d applied", curOp), aluOp, aluModel);
    endtask

    task automatic waitForReset(output bit ok);
        ok = 1'b0;
        for (int i = 0; i < 20 && !ok; i++) begin   // Timeout after 20 cycles
            step(7'd127);
            ok = (rstN === 1'b1);
        end
    endtask

    task automatic finishTest(input string name);
        $display("Test %-8s %0d checks, %0d errors", name,
                 checkCount - testChecks, errorCount - testErrors);
        testChecks = checkCount;
        testErrors = errorCount;
    endtask

    // ----------------------------------------
    // Tests
    // ----------------------------------------
    task automatic randomTest();
        int r;
        int runLen;
        int count;
        count = 0;
        while (count < 2000) begin
            r = $urandom_range(99, 0);
            if (r < 6) begin
                runLen = $urandom_range(5, 1);  // NOP run
                repeat (runLen) step(7'd96);
                count += runLen;
            end else if (r < 16) begin
                step(7'($urandom_range(127, 97)));  // Undefined range
                count++;
            end else begin
                step(7'($urandom_range(96, 0)));
                count++;
            end
        end
    endtask

    task automatic nopHoldTest();
        logic [6:0] op;
        int runLen;
        for (int k = 0; k < 40; k++) begin
            op = 7'($urandom_range(95, 0));
            runLen = $urandom_range(6, 2);
            step(op);
            for (int n = 0; n < runLen; n++) begin
                step(7'd96);
                checkEq($sformatf("aluOp held after opcode %0d", op), aluOp, expAlu(op));
            end
        end
    endtask

    task automatic droppedTest();
        for (int v = 0; v < 128; v++) begin
            if (isDropped(7'(v))) begin
                step(7'd19);                    // ADD leaves a nonzero code
                step(7'(v));
                checkEq($sformatf("strobes for dropped opcode %0d", v),
                        {push, pop, memWr, reqIn, outEn, ldi, sti, fft}, 32'd0);
                step(7'd19);
                checkEq($sformatf("aluOp for dropped opcode %0d", v), aluOp, 32'd0);
            end
        end
    endtask

    initial begin
        clk = 1'b0;
        opcode = 7'd127;
        curOp = 7'd127;
        aluModel = 6'd0;
        checkCount = 0;
        errorCount = 0;
        testChecks = 0;
        testErrors = 0;
        void'($urandom(seed));
        waitForReset(released);
        if (!released) begin
            $display("Timeout: reset release not seen within 20 cycles");
            $display("Result: FAILED");
        end else begin
            checkEq("aluOp after reset", aluOp, 32'd0);
            checkEq("strobes with opcode 127",
                    {push, pop, memWr, reqIn, outEn, ldi, sti, fft}, 32'd0);
            finishTest("reset");
            randomTest();
            finishTest("random");
            nopHoldTest();
            finishTest("nopHold");
            droppedTest();
            finishTest("dropped");
            errorCount += uut.uProps.failCount;     // Bound concurrent assertions
            $display("Total: %0d checks, %0d errors", checkCount, errorCount);
            if (errorCount == 0) begin
                $display("Result: PASSED");
            end else begin
                $display("Result: FAILED");
            end
        end
        $finish;
    end

endmodule

/* flist.f */
logic/instrDecPkg.sv
logic/opcodeMatch.sv
logic/ctrlStrobes.sv
logic/aluOpEncoder.sv
logic/instrDec.sv
testbench/instrDec_props.sv
testbench/instrDecTb.sv

/* Bender.yml */
package:
  name: instr_dec

sources:
  - logic/instrDecPkg.sv
  - logic/opcodeMatch.sv
  - logic/ctrlStrobes.sv
  - logic/aluOpEncoder.sv
  - logic/instrDec.sv
  - target: test
    files:
      - testbench/instrDec_props.sv
      - testbench/instrDecTb.sv
